//--- Bender.yml
package:
  name: fu_cdb

sources:
  - common/ooo_pkg.sv
  - fu/fu_alu.sv
  - fu/fu_mult.sv
  - fu/fu_bank.sv
  - cdb/cdb_select.sv
  - source/fu_cdb.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/fu_cdb_tb.sv

//--- cdb/cdb_select.sv
`timescale 1ns/1ns
`default_nettype none

module cdb_select
    import ooo_pkg::*;
#(
    parameter int NUM_ALU   = DEFAULT_NUM_ALU,
    parameter int NUM_MULT  = DEFAULT_NUM_MULT,
    parameter int CDB_WIDTH = DEFAULT_CDB_WIDTH
) (
    input  wire                                    clock,
    input  wire                                    rst_n,
    input  wire                                    squash,
    input  wire fu_result_t [NUM_MULT+NUM_ALU-1:0] fu_results,
    output logic [NUM_MULT+NUM_ALU-1:0]            select,
    output cdb_packet_t [CDB_WIDTH-1:0]            cdb_output
);

    localparam int NUM_FU = NUM_MULT + NUM_ALU;
    localparam int CNT_W  = $clog2(CDB_WIDTH + 1);

    logic [CNT_W-1:0]            grant_cnt;
    cdb_packet_t [CDB_WIDTH-1:0] cdb_next;

    function automatic cdb_packet_t to_cdb(input fu_result_t res);
        cdb_packet_t pkt;
        pkt.valid    = 1'b1;
        pkt.dest_prf = res.dest_prf;
        pkt.rob_idx  = res.rob_idx;
        pkt.value    = res.value;
        return pkt;
    endfunction

    // lowest index wins, so multipliers go before ALUs
    always_comb begin
        select    = '0;
        cdb_next  = '0;
        grant_cnt = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (fu_results[i].done && (grant_cnt < CNT_W'(CDB_WIDTH))) begin
                select[i]           = 1'b1;
                cdb_next[grant_cnt] = to_cdb(fu_results[i]);
                grant_cnt           = grant_cnt + CNT_W'(1);
            end
        end
    end

    // unused slots stay invalid
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cdb_output <= '0;
        end else if (squash) begin
            cdb_output <= '0;
        end else begin
            cdb_output <= cdb_next;
        end
    end

endmodule

`default_nettype wire

//--- common/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int XLEN      = 32;
    localparam int PRF_IDX_W = 6;
    localparam int ROB_IDX_W = 5;

    // top-level defaults
    localparam int DEFAULT_NUM_ALU     = 3;
    localparam int DEFAULT_NUM_MULT    = 2;
    localparam int DEFAULT_CDB_WIDTH   = 2;
    localparam int DEFAULT_MULT_STAGES = 4;

    typedef logic [XLEN-1:0]      data_t;
    typedef logic [PRF_IDX_W-1:0] prf_idx_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_SLL   = 4'h5,
        OP_SRL   = 4'h6,
        // signed compare
        OP_SLT   = 4'h7,
        // multiplier ops
        OP_MUL   = 4'h8,
        OP_MULHU = 4'h9
    } fu_op_e;

    // issue packet, 80 bits
    typedef struct packed {
        logic     valid;
        fu_op_e   op;
        data_t    rs1_value;
        data_t    rs2_value;
        prf_idx_t dest_prf;
        rob_idx_t rob_idx;
    } fu_packet_t;

    // result held inside a unit, 44 bits
    typedef struct packed {
        logic     done;
        prf_idx_t dest_prf;
        rob_idx_t rob_idx;
        data_t    value;
    } fu_result_t;

    // one bus slot, 44 bits
    typedef struct packed {
        logic     valid;
        prf_idx_t dest_prf;
        rob_idx_t rob_idx;
        data_t    value;
    } cdb_packet_t;

endpackage

`default_nettype wire

//--- fu/fu_alu.sv
`timescale 1ns/1ns
`default_nettype none

module fu_alu
    import ooo_pkg::*;
(
    input  wire        clock,
    input  wire        rst_n,
    input  wire        squash,
    input  wire        fu_packet_t issue,
    input  wire        select,
    output fu_result_t result,
    output logic       avail
);

    logic     done_q;
    prf_idx_t dest_q;
    rob_idx_t rob_q;
    data_t    value_q;
    data_t    alu_value;
    logic     accept;

    always_comb begin
        case (issue.op)
            OP_ADD:  alu_value = issue.rs1_value + issue.rs2_value;
            OP_SUB:  alu_value = issue.rs1_value - issue.rs2_value;
            OP_AND:  alu_value = issue.rs1_value & issue.rs2_value;
            OP_OR:   alu_value = issue.rs1_value | issue.rs2_value;
            OP_XOR:  alu_value = issue.rs1_value ^ issue.rs2_value;
            OP_SLL:  alu_value = issue.rs1_value << issue.rs2_value[4:0];
            OP_SRL:  alu_value = issue.rs1_value >> issue.rs2_value[4:0];
            OP_SLT: begin
                alu_value = {{(XLEN-1){1'b0}},
                             $signed(issue.rs1_value) < $signed(issue.rs2_value)};
            end
            default: alu_value = '0;
        endcase
    end

    // free, or the held result leaves at this edge
    assign avail  = !done_q || select;
    assign accept = issue.valid && avail;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (squash) begin
            done_q <= 1'b0;
        end else if (accept) begin
            done_q <= 1'b1;
        end else if (select) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            dest_q  <= issue.dest_prf;
            rob_q   <= issue.rob_idx;
            value_q <= alu_value;
        end
    end

    assign result = '{
        done:     done_q,
        dest_prf: dest_q,
        rob_idx:  rob_q,
        value:    value_q
    };

endmodule

`default_nettype wire

//--- fu/fu_bank.sv
`timescale 1ns/1ns
`default_nettype none

module fu_bank
    import ooo_pkg::*;
#(
    parameter int NUM_ALU     = DEFAULT_NUM_ALU,
    parameter int NUM_MULT    = DEFAULT_NUM_MULT,
    parameter int MULT_STAGES = DEFAULT_MULT_STAGES
) (
    input  wire                                    clock,
    input  wire                                    rst_n,
    input  wire                                    squash,
    input  wire fu_packet_t [NUM_ALU-1:0]          fu_alu_packet,
    input  wire fu_packet_t [NUM_MULT-1:0]         fu_mult_packet,
    input  wire [NUM_MULT+NUM_ALU-1:0]             select,
    output wire fu_result_t [NUM_MULT+NUM_ALU-1:0] fu_results,
    output wire [NUM_ALU-1:0]                      alu_avail,
    output wire [NUM_MULT-1:0]                     mult_avail
);

    // unit order: multipliers at 0..NUM_MULT-1, ALUs after them
    // the selector priority follows this order

    genvar m;
    genvar a;

    generate
        for (m = 0; m < NUM_MULT; m++) begin : g_mult
            fu_mult #(
                .MULT_STAGES(MULT_STAGES)
            ) u_mult (
                .clock  (clock),
                .rst_n  (rst_n),
                .squash (squash),
                .issue  (fu_mult_packet[m]),
                .select (select[m]),
                .result (fu_results[m]),
                .avail  (mult_avail[m])
            );
        end

        for (a = 0; a < NUM_ALU; a++) begin : g_alu
            fu_alu u_alu (
                .clock  (clock),
                .rst_n  (rst_n),
                .squash (squash),
                .issue  (fu_alu_packet[a]),
                .select (select[NUM_MULT+a]),
                .result (fu_results[NUM_MULT+a]),
                .avail  (alu_avail[a])
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- fu/fu_mult.sv
`timescale 1ns/1ns
`default_nettype none

module fu_mult
    import ooo_pkg::*;
#(
    parameter int MULT_STAGES = DEFAULT_MULT_STAGES
) (
    input  wire        clock,
    input  wire        rst_n,
    input  wire        squash,
    input  wire        fu_packet_t issue,
    input  wire        select,
    output fu_result_t result,
    output logic       avail
);

    // stages ahead of the held last stage
    localparam int MID = MULT_STAGES - 1;

    typedef struct packed {
        fu_op_e            op;
        prf_idx_t          dest_prf;
        rob_idx_t          rob_idx;
        logic [2*XLEN-1:0] product;
    } mult_stage_t;

    logic [MID-1:0]        stage_valid;
    mult_stage_t [MID-1:0] stage_q;
    logic [2*XLEN-1:0]     product;
    logic                  done_q;
    prf_idx_t              dest_q;
    rob_idx_t              rob_q;
    data_t                 value_q;
    logic                  advance;

    assign product = {{XLEN{1'b0}}, issue.rs1_value} * {{XLEN{1'b0}}, issue.rs2_value};

    // whole pipe holds while the tail waits for the bus
    assign advance = !done_q || select;
    assign avail   = advance;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
            done_q      <= 1'b0;
        end else if (squash) begin
            stage_valid <= '0;
            done_q      <= 1'b0;
        end else if (advance) begin
            stage_valid[0] <= issue.valid;
            for (int i = 1; i < MID; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
            done_q <= stage_valid[MID-1];
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            stage_q[0] <= '{
                op:       issue.op,
                dest_prf: issue.dest_prf,
                rob_idx:  issue.rob_idx,
                product:  product
            };
            for (int i = 1; i < MID; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
            dest_q <= stage_q[MID-1].dest_prf;
            rob_q  <= stage_q[MID-1].rob_idx;
            // half chosen on entry to the last stage
            if (stage_q[MID-1].op == OP_MULHU) begin
                value_q <= stage_q[MID-1].product[2*XLEN-1:XLEN];
            end else begin
                value_q <= stage_q[MID-1].product[XLEN-1:0];
            end
        end
    end

    assign result = '{
        done:     done_q,
        dest_prf: dest_q,
        rob_idx:  rob_q,
        value:    value_q
    };

endmodule

`default_nettype wire

//--- sim.f
common/ooo_pkg.sv
fu/fu_alu.sv
fu/fu_mult.sv
fu/fu_bank.sv
cdb/cdb_select.sv
source/fu_cdb.sv
verif/tb_clock.sv
verif/fu_cdb_tb.sv

//--- source/fu_cdb.sv
`timescale 1ns/1ns
`default_nettype none

module fu_cdb
    import ooo_pkg::*;
#(
    parameter int NUM_ALU     = DEFAULT_NUM_ALU,
    parameter int NUM_MULT    = DEFAULT_NUM_MULT,
    parameter int CDB_WIDTH   = DEFAULT_CDB_WIDTH,
    parameter int MULT_STAGES = DEFAULT_MULT_STAGES
) (
    input  wire                            clock,
    input  wire                            rst_n,
    input  wire                            squash,
    input  wire fu_packet_t [NUM_ALU-1:0]  fu_alu_packet,
    input  wire fu_packet_t [NUM_MULT-1:0] fu_mult_packet,
    output logic [NUM_ALU-1:0]             alu_avail,
    output logic [NUM_MULT-1:0]            mult_avail,
    output cdb_packet_t [CDB_WIDTH-1:0]    cdb_output
);

    fu_result_t [NUM_MULT+NUM_ALU-1:0] fu_results;
    logic [NUM_MULT+NUM_ALU-1:0]       select;

    fu_bank #(
        .NUM_ALU     (NUM_ALU),
        .NUM_MULT    (NUM_MULT),
        .MULT_STAGES (MULT_STAGES)
    ) u_fu_bank (
        .clock          (clock),
        .rst_n          (rst_n),
        .squash         (squash),
        .fu_alu_packet  (fu_alu_packet),
        .fu_mult_packet (fu_mult_packet),
        .select         (select),
        .fu_results     (fu_results),
        .alu_avail      (alu_avail),
        .mult_avail     (mult_avail)
    );

    // grants go back to the units in the same cycle
    cdb_select #(
        .NUM_ALU   (NUM_ALU),
        .NUM_MULT  (NUM_MULT),
        .CDB_WIDTH (CDB_WIDTH)
    ) u_cdb_select (
        .clock      (clock),
        .rst_n      (rst_n),
        .squash     (squash),
        .fu_results (fu_results),
        .select     (select),
        .cdb_output (cdb_output)
    );

endmodule

`default_nettype wire

//--- verif/fu_cdb_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fu_cdb_tb
    import ooo_pkg::*;
();

    localparam int NUM_ALU     = DEFAULT_NUM_ALU;
    localparam int NUM_MULT    = DEFAULT_NUM_MULT;
    localparam int CDB_WIDTH   = DEFAULT_CDB_WIDTH;
    localparam int MULT_STAGES = DEFAULT_MULT_STAGES;
    localparam int NUM_FU      = NUM_ALU + NUM_MULT;
    localparam int PERIOD      = 8;
    localparam int WAIT_LIMIT  = 16;
    // reset, 8 alu ops, pipelining, contention, priority, squash
    localparam int BUDGET_CYCLES = 4 + 8 * (WAIT_LIMIT + 1) + (WAIT_LIMIT + 4)
                                 + (WAIT_LIMIT + 2) + (WAIT_LIMIT + 2) + (2 * MULT_STAGES + 4);
    localparam int MARGIN_CYCLES = 50;

    logic                        clock;
    logic                        rst_n;
    logic                        squash;
    fu_packet_t [NUM_ALU-1:0]    alu_pkt;
    fu_packet_t [NUM_MULT-1:0]   mult_pkt;
    logic [NUM_ALU-1:0]          alu_avail;
    logic [NUM_MULT-1:0]         mult_avail;
    cdb_packet_t [CDB_WIDTH-1:0] cdb_output;
    logic [NUM_FU-1:0]           avail_all;

    string cur_test;
    int    err_count;
    int    check_count;
    int    test_errors;
    int    tests_run;
    int    tests_failed;

    tb_clock #(.PERIOD(PERIOD)) u_clock (.clock(clock));

    fu_cdb #(
        .NUM_ALU     (NUM_ALU),
        .NUM_MULT    (NUM_MULT),
        .CDB_WIDTH   (CDB_WIDTH),
        .MULT_STAGES (MULT_STAGES)
    ) UUT (
        .clock          (clock),
        .rst_n          (rst_n),
        .squash         (squash),
        .fu_alu_packet  (alu_pkt),
        .fu_mult_packet (mult_pkt),
        .alu_avail      (alu_avail),
        .mult_avail     (mult_avail),
        .cdb_output     (cdb_output)
    );

    assign avail_all = {mult_avail, alu_avail};

    // expected results straight from the opcode definitions
    function automatic data_t ref_value(input fu_op_e op, input data_t a, input data_t b);
        logic [2*XLEN-1:0] wide;
        data_t             r;
        wide = 64'(a) * 64'(b);
        case (op)
            OP_ADD:   r = a + b;
            OP_SUB:   r = a + ~b + 32'd1;
            OP_AND:   r = a & b;
            OP_OR:    r = a | b;
            OP_XOR:   r = a ^ b;
            OP_SLL:   r = a << b[4:0];
            OP_SRL:   r = a >> b[4:0];
            OP_SLT:   r = (a[XLEN-1] != b[XLEN-1]) ? data_t'(a[XLEN-1]) : data_t'(a < b);
            OP_MUL:   r = wide[XLEN-1:0];
            OP_MULHU: r = wide[2*XLEN-1:XLEN];
            default:  r = '0;
        endcase
        return r;
    endfunction

    function automatic fu_packet_t make_pkt(input fu_op_e op, input data_t a, input data_t b,
                                            input int prf, input int rob);
        fu_packet_t p;
        p.valid     = 1'b1;
        p.op        = op;
        p.rs1_value = a;
        p.rs2_value = b;
        p.dest_prf  = prf_idx_t'(prf);
        p.rob_idx   = rob_idx_t'(rob);
        return p;
    endfunction

    function automatic cdb_packet_t expect_cdb(input fu_packet_t p);
        cdb_packet_t c;
        c.valid    = 1'b1;
        c.dest_prf = p.dest_prf;
        c.rob_idx  = p.rob_idx;
        c.value    = ref_value(p.op, p.rs1_value, p.rs2_value);
        return c;
    endfunction

    function automatic string cdb_to_str(input cdb_packet_t c);
        return $sformatf("valid=%b prf=%0d rob=%0d value=%h",
                         c.valid, c.dest_prf, c.rob_idx, c.value);
    endfunction

    function automatic logic any_valid();
        logic v;
        v = 1'b0;
        for (int s = 0; s < CDB_WIDTH; s++) begin
            v = v | cdb_output[s].valid;
        end
        return v;
    endfunction

    task automatic note_error();
        err_count++;
        test_errors++;
    endtask

    task automatic compare_cdb(input cdb_packet_t exp, input cdb_packet_t act);
        check_count++;
        if (act !== exp) begin
            $display("ERR %s: expected %s, actual %s",
                     cur_test, cdb_to_str(exp), cdb_to_str(act));
            note_error();
        end
    endtask

    task automatic compare_avail(input logic [NUM_FU-1:0] exp, input logic [NUM_FU-1:0] act);
        check_count++;
        if (act !== exp) begin
            $display("ERR %s: expected avail=%b actual avail=%b", cur_test, exp, act);
            note_error();
        end
    endtask

    task automatic compare_latency(input int exp, input int act);
        check_count++;
        if (act != exp) begin
            $display("ERR %s: expected latency=%0d actual latency=%0d", cur_test, exp, act);
            note_error();
        end
    endtask

    task automatic idle_inputs();
        alu_pkt  = '0;
        mult_pkt = '0;
        squash   = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %-12s ok", cur_test);
        end else begin
            $display("test %-12s failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    // steps falling edges until a bus slot is valid, counting from start
    task automatic wait_valid(input int start, output int cycles);
        cycles = start;
        while (!any_valid() && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!any_valid()) begin
            $display("%s: no valid bus slot within %0d cycles", cur_test, WAIT_LIMIT);
            note_error();
        end
    endtask

    task automatic check_reset();
        start_test("reset");
        @(negedge clock);
        for (int s = 0; s < CDB_WIDTH; s++) begin
            compare_cdb('0, cdb_output[s]);
        end
        compare_avail('1, avail_all);
        finish_test();
    endtask

    task automatic check_alu_ops();
        fu_op_e     ops[8] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SLT};
        fu_packet_t p;
        int         lat;
        start_test("alu_ops");
        for (int i = 0; i < 8; i++) begin
            p = make_pkt(ops[i], $urandom(), $urandom(), 8 + i, i);
            alu_pkt[0] = p;
            @(negedge clock);
            idle_inputs();
            wait_valid(1, lat);
            compare_latency(2, lat);
            compare_cdb(expect_cdb(p), cdb_output[0]);
            compare_cdb('0, cdb_output[1]);
        end
        finish_test();
    endtask

    task automatic check_mult_pipe();
        fu_packet_t p[4];
        int         lat;
        start_test("mult_pipe");
        for (int i = 0; i < 4; i++) begin
            p[i] = make_pkt((i % 2 == 0) ? OP_MUL : OP_MULHU, $urandom(), $urandom(),
                            20 + i, 4 + i);
            mult_pkt[0] = p[i];
            @(negedge clock);
        end
        idle_inputs();
        // four ops issued, so four cycles have passed since the first
        wait_valid(4, lat);
        compare_latency(MULT_STAGES + 1, lat);
        compare_cdb(expect_cdb(p[0]), cdb_output[0]);
        compare_cdb('0, cdb_output[1]);
        for (int i = 1; i < 4; i++) begin
            @(negedge clock);
            compare_cdb(expect_cdb(p[i]), cdb_output[0]);
            compare_cdb('0, cdb_output[1]);
        end
        finish_test();
    endtask

    task automatic check_contention();
        fu_packet_t p[NUM_ALU];
        int         lat;
        start_test("contention");
        for (int a = 0; a < NUM_ALU; a++) begin
            p[a] = make_pkt(fu_op_e'(4'($urandom_range(7))), $urandom(), $urandom(),
                            30 + a, 10 + a);
            alu_pkt[a] = p[a];
        end
        @(negedge clock);
        idle_inputs();
        // ALU 2 lost the bus, so it cannot take a new op
        compare_avail({{NUM_MULT{1'b1}}, 3'b011}, avail_all);
        wait_valid(1, lat);
        compare_latency(2, lat);
        compare_cdb(expect_cdb(p[0]), cdb_output[0]);
        compare_cdb(expect_cdb(p[1]), cdb_output[1]);
        compare_avail('1, avail_all);
        @(negedge clock);
        compare_cdb(expect_cdb(p[2]), cdb_output[0]);
        compare_cdb('0, cdb_output[1]);
        finish_test();
    endtask

    task automatic check_priority();
        fu_packet_t m0;
        fu_packet_t m1;
        fu_packet_t al;
        int         lat;
        start_test("priority");
        m0 = make_pkt(OP_MUL, $urandom(), $urandom(), 40, 16);
        m1 = make_pkt(OP_MULHU, $urandom(), $urandom(), 41, 17);
        al = make_pkt(OP_XOR, $urandom(), $urandom(), 42, 18);
        mult_pkt[0] = m0;
        mult_pkt[1] = m1;
        @(negedge clock);
        idle_inputs();
        repeat (MULT_STAGES - 2) @(negedge clock);
        // ALU finishes on the same edge as both multipliers
        alu_pkt[0] = al;
        @(negedge clock);
        idle_inputs();
        compare_avail({{NUM_MULT{1'b1}}, 3'b110}, avail_all);
        wait_valid(MULT_STAGES, lat);
        compare_latency(MULT_STAGES + 1, lat);
        compare_cdb(expect_cdb(m0), cdb_output[0]);
        compare_cdb(expect_cdb(m1), cdb_output[1]);
        @(negedge clock);
        compare_cdb(expect_cdb(al), cdb_output[0]);
        compare_cdb('0, cdb_output[1]);
        finish_test();
    endtask

    task automatic check_squash();
        start_test("squash");
        mult_pkt[0] = make_pkt(OP_MUL, $urandom(), $urandom(), 50, 20);
        mult_pkt[1] = make_pkt(OP_MULHU, $urandom(), $urandom(), 51, 21);
        @(negedge clock);
        idle_inputs();
        repeat (MULT_STAGES - 2) @(negedge clock);
        alu_pkt[0] = make_pkt(OP_ADD, $urandom(), $urandom(), 52, 22);
        @(negedge clock);
        idle_inputs();
        // multipliers granted, ALU 0 held, nothing on the bus yet
        compare_avail({{NUM_MULT{1'b1}}, 3'b110}, avail_all);
        squash     = 1'b1;
        alu_pkt[1] = make_pkt(OP_SUB, $urandom(), $urandom(), 53, 23);
        @(negedge clock);
        idle_inputs();
        repeat (MULT_STAGES + 3) begin
            for (int s = 0; s < CDB_WIDTH; s++) begin
                compare_cdb('0, cdb_output[s]);
            end
            @(negedge clock);
        end
        compare_avail('1, avail_all);
        finish_test();
    endtask

    initial begin
        #((BUDGET_CYCLES + MARGIN_CYCLES) * PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not finish",
                 BUDGET_CYCLES + MARGIN_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        err_count    = 0;
        check_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h0a0d_6373));
        rst_n = 1'b0;
        idle_inputs();
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        check_reset();
        check_alu_ops();
        check_mult_pipe();
        check_contention();
        check_priority();
        check_squash();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD/2) clock = ~clock;
    end

endmodule

`default_nettype wire
